/* radio_core.f */
rtl/radio_core_pkg.sv
rtl/rx_frontend.sv
rtl/tx_frontend.sv
rtl/capture_engine.sv
rtl/sample_arbiter.sv
rtl/sample_ram.sv
rtl/radio_core.sv
test/radio_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the radio_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module radio_core_tb \
   -f radio_core.f -o radio_core_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/radio_core_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "all tests passed"; then
   exit 0
fi
exit 1

/* test/radio_core_tb.sv */
`timescale 1ns/1ps

module radio_core_tb;
   import radio_core_pkg::*;

   typedef struct packed {
      logic [6:0]  len0;     // 0 keeps the radio out of the row
      logic [6:0]  len1;
      logic [1:0]  gap;      // strobe spacing in cycles
      logic        swap0;
      logic [15:0] ofs_i;
      logic [15:0] ofs_q;
      logic        exp_ovf;
   } cap_row_t;

   typedef struct packed {
      logic        radio;
      logic [15:0] in_i;
      logic [15:0] in_q;
      logic [15:0] ofs_i;
      logic [15:0] ofs_q;
   } tx_row_t;

   localparam int NUM_CAP  = 4;
   localparam int NUM_TX   = 4;
   localparam int WAIT_MAX = 400;
   localparam logic [7:0] BASE [2] = '{8'd224, 8'd232};

   localparam cap_row_t CAP_ROWS [NUM_CAP] = '{
      '{7'd8,  7'd0,  2'd2, 1'b1, 16'h1234, 16'hfe0c, 1'b0},  // swap, radio 0 alone
      '{7'd32, 7'd20, 2'd2, 1'b0, 16'h0040, 16'hffc0, 1'b0},  // both radios at once
      '{7'd10, 7'd10, 2'd1, 1'b0, 16'h0000, 16'h0000, 1'b1},  // every cycle, overflow
      '{7'd4,  7'd40, 2'd2, 1'b0, 16'h7fff, 16'h8001, 1'b0}   // radio 1 length clamp
   };

   localparam tx_row_t TX_ROWS [NUM_TX] = '{
      '{1'b0, 16'h1000, 16'hf000, 16'h0100, 16'hff00},
      '{1'b0, 16'h7f00, 16'h8100, 16'h0200, 16'hfe00},  // +sat I, -sat Q
      '{1'b1, 16'h8000, 16'h7fff, 16'hffff, 16'h0001},  // -sat I, +sat Q
      '{1'b1, 16'h0005, 16'hfffb, 16'h8000, 16'h7fff}
   };

   logic              radio_clk;
   logic              i_rst_n;
   logic              set_stb;
   logic [7:0]        set_addr;
   logic [31:0]       set_data;
   iq_sample_t        rx_val  [2];
   logic              rx_stb  [2];
   iq_sample_t        tx_val  [2];
   iq_sample_t        tx_out  [2];
   logic [RAM_AW-1:0] rd_addr;
   iq_sample_t        rd_data;
   logic [1:0]        cap_done;
   logic [1:0]        cap_ovf;

   iq_sample_t stim    [2][64];
   iq_sample_t exp_mem [64];   // expected memory image
   logic       known   [64];
   int         errors;
   int         seed_val;

   radio_core UUT (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
      .i_rx0(rx_val[0]), .i_rx1(rx_val[1]), .i_rx_stb0(rx_stb[0]), .i_rx_stb1(rx_stb[1]),
      .i_tx0(tx_val[0]), .i_tx1(tx_val[1]), .o_tx0(tx_out[0]), .o_tx1(tx_out[1]),
      .i_rd_addr(rd_addr), .o_rd_data(rd_data),
      .o_cap_done(cap_done), .o_cap_overflow(cap_ovf)
   );

   initial begin
      radio_clk = 1'b0;
      forever #2 radio_clk = ~radio_clk;
   end

   //////////////////////////////////////////////////
   // reference model
   function automatic comp_t clip16(input int v);
      if (v > 32767) return comp_t'(16'h7fff);
      if (v < -32768) return comp_t'(16'h8000);
      return v[15:0];
   endfunction

   function automatic iq_sample_t rx_model(input iq_sample_t s, input logic [15:0] oi,
                                           input logic [15:0] oq, input logic sw);
      comp_t ci;
      comp_t cq;
      ci = clip16(int'(comp_t'(s[31:16])) - int'(comp_t'(oi)));
      cq = clip16(int'(comp_t'(s[15:0])) - int'(comp_t'(oq)));
      return sw ? {cq, ci} : {ci, cq};
   endfunction

   function automatic iq_sample_t tx_model(input iq_sample_t s, input logic [15:0] oi,
                                           input logic [15:0] oq);
      comp_t ci;
      comp_t cq;
      ci = clip16(int'(comp_t'(s[31:16])) + int'(comp_t'(oi)));
      cq = clip16(int'(comp_t'(s[15:0])) + int'(comp_t'(oq)));
      return {ci, cq};
   endfunction

   //////////////////////////////////////////////////
   // compare and bus tasks, all start and end on a falling edge
   task automatic check_sample(input iq_sample_t got, input iq_sample_t exp, input string what);
      if (got !== exp) begin
         $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("Fail at %0t: %s got %b expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic set_write(input logic [7:0] addr, input logic [31:0] data);
      set_stb  = 1'b1;
      set_addr = addr;
      set_data = data;
      @(negedge radio_clk);
      set_stb  = 1'b0;
   endtask

   task automatic read_word(input int addr, output iq_sample_t data);
      rd_addr = RAM_AW'(addr);
      @(negedge radio_clk);  // one cycle read latency
      data = rd_data;
   endtask

   task automatic run_tx_row(input int n);
      tx_row_t    row;
      int         r;
      iq_sample_t exp;
      row = TX_ROWS[n];
      r   = int'(row.radio);
      set_write(BASE[r] + 8'(SR_TX_OFFSET_I), 32'(row.ofs_i));
      set_write(BASE[r] + 8'(SR_TX_OFFSET_Q), 32'(row.ofs_q));
      tx_val[r] = {row.in_i, row.in_q};
      exp = tx_model(tx_val[r], row.ofs_i, row.ofs_q);
      @(negedge radio_clk);
      check_sample(tx_out[r], exp, $sformatf("tx row %0d", n));
   endtask

   task automatic run_cap_row(input int n);
      cap_row_t   row;
      int         len [2];
      int         sent [2];
      int         cyc;
      logic       done_seen [2];
      logic       ovf_seen [2];
      iq_sample_t got;
      row    = CAP_ROWS[n];
      len[0] = int'(row.len0);
      len[1] = int'(row.len1);
      for (int r = 0; r < 2; r++) begin
         set_write(BASE[r] + 8'(SR_RX_OFFSET_I), 32'(row.ofs_i));
         set_write(BASE[r] + 8'(SR_RX_OFFSET_Q), 32'(row.ofs_q));
         for (int k = 0; k < 64; k++) stim[r][k] = $urandom();
      end
      set_write(BASE[0] + 8'(SR_RX_SWAP), 32'(row.swap0));
      for (int r = 0; r < 2; r++) begin
         if (len[r] != 0) set_write(BASE[r] + 8'(SR_CAP_LEN), 32'(len[r]));
      end
      for (int r = 0; r < 2; r++) begin
         if (len[r] != 0) begin
            check_flag(cap_done[r], 1'b0, $sformatf("row %0d done cleared r%0d", n, r));
            check_flag(cap_ovf[r], 1'b0, $sformatf("row %0d overflow cleared r%0d", n, r));
         end
         done_seen[r] = (len[r] == 0);
         ovf_seen[r]  = 1'b0;
         sent[r]      = 0;
      end
      cyc = 0;
      while (!(done_seen[0] && done_seen[1]) && cyc < WAIT_MAX) begin
         for (int r = 0; r < 2; r++) begin
            if (cap_done[r]) done_seen[r] = 1'b1;
            if (cap_ovf[r] && len[r] != 0) ovf_seen[r] = 1'b1;
            rx_stb[r] = 1'b0;
            if (!done_seen[r] && (cyc % int'(row.gap)) == 0 && sent[r] < 64) begin
               rx_val[r] = stim[r][sent[r]];
               rx_stb[r] = 1'b1;
               sent[r]++;
            end
         end
         @(negedge radio_clk);
         cyc++;
      end
      rx_stb[0] = 1'b0;
      rx_stb[1] = 1'b0;
      if (!(done_seen[0] && done_seen[1])) begin
         $display("capture done never rose in row %0d within %0d cycles", n, WAIT_MAX);
         errors++;
      end
      for (int r = 0; r < 2; r++) begin
         if (len[r] != 0) begin
            check_flag(ovf_seen[r], row.exp_ovf, $sformatf("row %0d overflow r%0d", n, r));
            for (int j = 0; j < len[r] && j < CAP_DEPTH; j++) begin
               exp_mem[r*CAP_DEPTH + j] = rx_model(stim[r][j], row.ofs_i, row.ofs_q,
                                                  (r == 0) ? row.swap0 : 1'b0);
               known[r*CAP_DEPTH + j] = !row.exp_ovf;  // dropped samples leave holes
            end
         end
      end
      // whole image, so untouched words are checked too
      for (int a = 0; a < 64; a++) begin
         if (known[a]) begin
            read_word(a, got);
            check_sample(got, exp_mem[a], $sformatf("row %0d word %0d", n, a));
         end
      end
   endtask

   //////////////////////////////////////////////////
   // main sequence
   initial begin
      errors   = 0;
      i_rst_n  = 1'b0;
      set_stb  = 1'b0;
      set_addr = '0;
      set_data = '0;
      rd_addr  = '0;
      for (int r = 0; r < 2; r++) begin
         rx_val[r] = '0;
         rx_stb[r] = 1'b0;
         tx_val[r] = 32'h1234_5678;  // nonzero input, output held at zero by reset
      end
      for (int a = 0; a < 64; a++) known[a] = 1'b0;
      seed_val = $urandom(32'h9877);

      repeat (5) @(posedge radio_clk);
      @(negedge radio_clk);
      i_rst_n = 1'b1;
      for (int r = 0; r < 2; r++) begin
         check_flag(cap_done[r], 1'b0, $sformatf("reset done r%0d", r));
         check_flag(cap_ovf[r], 1'b0, $sformatf("reset overflow r%0d", r));
         check_sample(tx_out[r], '0, $sformatf("reset tx r%0d", r));
      end

      for (int n = 0; n < NUM_TX; n++) run_tx_row(n);
      for (int n = 0; n < NUM_CAP; n++) run_cap_row(n);

      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* rtl/radio_core.sv */
`timescale 1ns/1ps

module radio_core #(
   parameter logic [radio_core_pkg::SET_ADDR_W-1:0] RADIO0_BASE = 8'd224,
   parameter logic [radio_core_pkg::SET_ADDR_W-1:0] RADIO1_BASE = 8'd232
) (
   input  logic                                  radio_clk,
   input  logic                                  i_rst_n,
   input  logic                                  i_set_stb,
   input  logic [radio_core_pkg::SET_ADDR_W-1:0] i_set_addr,
   input  logic [radio_core_pkg::SET_DATA_W-1:0] i_set_data,
   input  radio_core_pkg::iq_sample_t            i_rx0,
   input  radio_core_pkg::iq_sample_t            i_rx1,
   input  logic                                  i_rx_stb0,
   input  logic                                  i_rx_stb1,
   input  radio_core_pkg::iq_sample_t            i_tx0,
   input  radio_core_pkg::iq_sample_t            i_tx1,
   output radio_core_pkg::iq_sample_t            o_tx0,
   output radio_core_pkg::iq_sample_t            o_tx1,
   input  logic [radio_core_pkg::RAM_AW-1:0]     i_rd_addr,
   output radio_core_pkg::iq_sample_t            o_rd_data,
   output logic [1:0]                            o_cap_done,
   output logic [1:0]                            o_cap_overflow
);
   import radio_core_pkg::*;

   iq_sample_t        adc      [2];
   logic              adc_stb  [2];
   iq_sample_t        rx_fe    [2];
   logic              rx_fe_stb[2];
   iq_sample_t        tx_in    [2];
   iq_sample_t        tx_out   [2];
   logic [1:0]        req;
   logic [1:0]        grant;
   logic [RAM_AW-2:0] wr_addr  [2];
   iq_sample_t        wr_data  [2];
   logic              ram_we;
   logic [RAM_AW-1:0] ram_addr;
   iq_sample_t        ram_data;

   assign adc[0]     = i_rx0;
   assign adc[1]     = i_rx1;
   assign adc_stb[0] = i_rx_stb0;
   assign adc_stb[1] = i_rx_stb1;
   assign tx_in[0]   = i_tx0;
   assign tx_in[1]   = i_tx1;
   assign o_tx0      = tx_out[0];
   assign o_tx1      = tx_out[1];

   //////////////////////////////////////////////////
   // per radio front ends and capture
   for (genvar g = 0; g < 2; g++) begin : g_radio
      localparam logic [SET_ADDR_W-1:0] BASE = (g == 0) ? RADIO0_BASE : RADIO1_BASE;

      rx_frontend #(.CHAN_BASE(BASE)) u_rx_fe (
         .radio_clk(radio_clk), .i_rst_n(i_rst_n),
         .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
         .i_adc(adc[g]), .i_adc_stb(adc_stb[g]),
         .o_rx(rx_fe[g]), .o_rx_stb(rx_fe_stb[g])
      );

      tx_frontend #(.CHAN_BASE(BASE)) u_tx_fe (
         .radio_clk(radio_clk), .i_rst_n(i_rst_n),
         .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
         .i_tx(tx_in[g]), .o_dac(tx_out[g])
      );

      capture_engine #(.CHAN_BASE(BASE)) u_cap (
         .radio_clk(radio_clk), .i_rst_n(i_rst_n),
         .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
         .i_rx(rx_fe[g]), .i_rx_stb(rx_fe_stb[g]), .i_grant(grant[g]),
         .o_req(req[g]), .o_wr_addr(wr_addr[g]), .o_wr_data(wr_data[g]),
         .o_cap_done(o_cap_done[g]), .o_cap_overflow(o_cap_overflow[g])
      );
   end

   //////////////////////////////////////////////////
   // shared capture memory
   sample_arbiter u_arb (
      .radio_clk(radio_clk), .i_rst_n(i_rst_n),
      .i_req(req),
      .i_wr_addr0(wr_addr[0]), .i_wr_addr1(wr_addr[1]),
      .i_wr_data0(wr_data[0]), .i_wr_data1(wr_data[1]),
      .o_grant(grant), .o_ram_we(ram_we),
      .o_ram_addr(ram_addr), .o_ram_data(ram_data)
   );

   sample_ram u_ram (
      .radio_clk(radio_clk),
      .i_we(ram_we), .i_wr_addr(ram_addr), .i_wr_data(ram_data),
      .i_rd_addr(i_rd_addr), .o_rd_data(o_rd_data)  // readback port
   );

endmodule

/* rtl/sample_ram.sv */
`timescale 1ns/1ps

module sample_ram (
   input  logic                              radio_clk,
   input  logic                              i_we,
   input  logic [radio_core_pkg::RAM_AW-1:0] i_wr_addr,
   input  radio_core_pkg::iq_sample_t        i_wr_data,
   input  logic [radio_core_pkg::RAM_AW-1:0] i_rd_addr,
   output radio_core_pkg::iq_sample_t        o_rd_data
);
   import radio_core_pkg::*;

   iq_sample_t mem [2**RAM_AW];

   always_ff @(posedge radio_clk) begin
      if (i_we) mem[i_wr_addr] <= i_wr_data;
      o_rd_data <= mem[i_rd_addr];  // old data on a same address collision
   end

endmodule

/* rtl/sample_arbiter.sv */
`timescale 1ns/1ps

module sample_arbiter (
   input  logic                              radio_clk,
   input  logic                              i_rst_n,
   input  logic [1:0]                        i_req,
   input  logic [radio_core_pkg::RAM_AW-2:0] i_wr_addr0,
   input  logic [radio_core_pkg::RAM_AW-2:0] i_wr_addr1,
   input  radio_core_pkg::iq_sample_t        i_wr_data0,
   input  radio_core_pkg::iq_sample_t        i_wr_data1,
   output logic [1:0]                        o_grant,
   output logic                              o_ram_we,
   output logic [radio_core_pkg::RAM_AW-1:0] o_ram_addr,
   output radio_core_pkg::iq_sample_t        o_ram_data
);

   logic last_grant;  // index of the engine served last
   logic sel;

   // lone requester always wins, a tie goes to the one not served last
   always_comb begin
      o_grant = i_req;
      if (&i_req) o_grant = last_grant ? 2'b01 : 2'b10;
   end

   assign sel        = o_grant[1];
   assign o_ram_we   = |i_req;
   assign o_ram_addr = {sel, sel ? i_wr_addr1 : i_wr_addr0};  // msb is the region
   assign o_ram_data = sel ? i_wr_data1 : i_wr_data0;

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n)      last_grant <= 1'b0;
      else if (o_ram_we) last_grant <= sel;
   end

endmodule

/* rtl/capture_engine.sv */
`timescale 1ns/1ps

module capture_engine #(
   parameter logic [radio_core_pkg::SET_ADDR_W-1:0] CHAN_BASE = 8'd224
) (
   input  logic                                  radio_clk,
   input  logic                                  i_rst_n,
   input  logic                                  i_set_stb,
   input  logic [radio_core_pkg::SET_ADDR_W-1:0] i_set_addr,
   input  logic [radio_core_pkg::SET_DATA_W-1:0] i_set_data,
   input  radio_core_pkg::iq_sample_t            i_rx,
   input  logic                                  i_rx_stb,
   input  logic                                  i_grant,
   output logic                                  o_req,
   output logic [radio_core_pkg::RAM_AW-2:0]     o_wr_addr,
   output radio_core_pkg::iq_sample_t            o_wr_data,
   output logic                                  o_cap_done,
   output logic                                  o_cap_overflow
);
   import radio_core_pkg::*;

   localparam int CNT_W = $clog2(CAP_DEPTH) + 1;

   cap_state_e            state;
   logic [SET_ADDR_W-1:0] set_off;
   logic                  len_wr;
   logic [CNT_W-1:0]      len_req;
   logic [CNT_W-1:0]      len_clamp;
   logic [CNT_W-1:0]      remain;     // samples still to accept
   logic [RAM_AW-2:0]     wr_addr;
   logic                  take;
   logic                  room;
   logic                  overflow;

   assign set_off   = i_set_addr - CHAN_BASE;
   assign len_wr    = i_set_stb && (set_off == SET_ADDR_W'(SR_CAP_LEN));
   assign len_req   = i_set_data[CNT_W-1:0];
   assign len_clamp = (len_req > CNT_W'(CAP_DEPTH)) ? CNT_W'(CAP_DEPTH) : len_req;

   assign take = i_rx_stb && (state == CAP_RUN) && (remain != '0);
   assign room = !o_req || i_grant;  // holding reg empties on this edge

   assign o_wr_addr      = wr_addr;
   assign o_cap_done     = (state == CAP_DONE);
   assign o_cap_overflow = overflow;

   //////////////////////////////////////////////////
   // control fsm
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state    <= CAP_IDLE;
         remain   <= '0;
         wr_addr  <= '0;
         o_req    <= 1'b0;
         overflow <= 1'b0;
      end else if (len_wr) begin
         // new length restarts the capture, pending sample is abandoned
         state    <= (len_clamp == '0) ? CAP_IDLE : CAP_RUN;
         remain   <= len_clamp;
         wr_addr  <= '0;
         o_req    <= 1'b0;
         overflow <= 1'b0;
      end else begin
         if (i_grant) begin
            wr_addr <= wr_addr + 1'b1;
            if (remain == '0) state <= CAP_DONE;  // last sample just landed
         end
         if (take && room) begin
            o_req  <= 1'b1;
            remain <= remain - 1'b1;
         end else if (i_grant) begin
            o_req <= 1'b0;
         end
         if (take && !room) overflow <= 1'b1;  // sticky until next length write
      end
   end

   // holding register
   always_ff @(posedge radio_clk) begin
      if (take && room) o_wr_data <= i_rx;
   end

endmodule

/* rtl/tx_frontend.sv */
`timescale 1ns/1ps

module tx_frontend #(
   parameter logic [radio_core_pkg::SET_ADDR_W-1:0] CHAN_BASE = 8'd224
) (
   input  logic                                  radio_clk,
   input  logic                                  i_rst_n,
   input  logic                                  i_set_stb,
   input  logic [radio_core_pkg::SET_ADDR_W-1:0] i_set_addr,
   input  logic [radio_core_pkg::SET_DATA_W-1:0] i_set_data,
   input  radio_core_pkg::iq_sample_t            i_tx,
   output radio_core_pkg::iq_sample_t            o_dac
);
   import radio_core_pkg::*;

   comp_t                 offset_i;
   comp_t                 offset_q;
   logic [SET_ADDR_W-1:0] set_off;
   logic signed [16:0]    sum_i;
   logic signed [16:0]    sum_q;

   assign set_off = i_set_addr - CHAN_BASE;

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         offset_i <= '0;
         offset_q <= '0;
      end else if (i_set_stb && (set_off[SET_ADDR_W-1:3] == '0)) begin
         case (sr_offset_e'(set_off[2:0]))
            SR_TX_OFFSET_I: offset_i <= i_set_data[15:0];
            SR_TX_OFFSET_Q: offset_q <= i_set_data[15:0];
            default: ;
         endcase
      end
   end

   assign sum_i = comp_t'(i_tx[31:16]) + offset_i;
   assign sum_q = comp_t'(i_tx[15:0]) + offset_q;

   // dac path runs every cycle, no strobe
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) o_dac <= '0;
      else          o_dac <= {sat_comp(sum_i), sat_comp(sum_q)};
   end

endmodule

/* rtl/rx_frontend.sv */
`timescale 1ns/1ps

module rx_frontend #(
   parameter logic [radio_core_pkg::SET_ADDR_W-1:0] CHAN_BASE = 8'd224
) (
   input  logic                                  radio_clk,
   input  logic                                  i_rst_n,
   input  logic                                  i_set_stb,
   input  logic [radio_core_pkg::SET_ADDR_W-1:0] i_set_addr,
   input  logic [radio_core_pkg::SET_DATA_W-1:0] i_set_data,
   input  radio_core_pkg::iq_sample_t            i_adc,
   input  logic                                  i_adc_stb,
   output radio_core_pkg::iq_sample_t            o_rx,
   output logic                                  o_rx_stb
);
   import radio_core_pkg::*;

   comp_t                 offset_i;
   comp_t                 offset_q;
   logic                  swap_iq;
   logic [SET_ADDR_W-1:0] set_off;
   logic                  set_hit;
   logic signed [16:0]    diff_i;
   logic signed [16:0]    diff_q;
   comp_t                 cor_i;
   comp_t                 cor_q;

   // offset relative to our block, wraps for addresses below the base
   assign set_off = i_set_addr - CHAN_BASE;
   assign set_hit = i_set_stb && (set_off[SET_ADDR_W-1:3] == '0);

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         offset_i <= '0;
         offset_q <= '0;
         swap_iq  <= 1'b0;
      end else if (set_hit) begin
         case (sr_offset_e'(set_off[2:0]))
            SR_RX_OFFSET_I: offset_i <= i_set_data[15:0];
            SR_RX_OFFSET_Q: offset_q <= i_set_data[15:0];
            SR_RX_SWAP:     swap_iq  <= i_set_data[0];
            default: ;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // dc offset removal
   assign diff_i = comp_t'(i_adc[31:16]) - offset_i;
   assign diff_q = comp_t'(i_adc[15:0]) - offset_q;
   assign cor_i  = sat_comp(diff_i);
   assign cor_q  = sat_comp(diff_q);

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) o_rx_stb <= 1'b0;
      else          o_rx_stb <= i_adc_stb;
   end

   always_ff @(posedge radio_clk) begin
      if (i_adc_stb) o_rx <= swap_iq ? {cor_q, cor_i} : {cor_i, cor_q};  // swap after correction
   end

endmodule

/* rtl/radio_core_pkg.sv */
package radio_core_pkg;

   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   // one I or Q component, sample packs I high and Q low
   typedef logic signed [15:0] comp_t;
   typedef logic [31:0] iq_sample_t;

   // register offsets inside one radio's settings block
   typedef enum logic [2:0] {
      SR_RX_OFFSET_I = 3'd0,
      SR_RX_OFFSET_Q = 3'd1,
      SR_RX_SWAP     = 3'd2,
      SR_TX_OFFSET_I = 3'd3,
      SR_TX_OFFSET_Q = 3'd4,
      SR_CAP_LEN     = 3'd5
   } sr_offset_e;

   localparam int CAP_DEPTH = 32;  // words per radio region
   localparam int RAM_AW    = 6;   // msb picks the radio

   typedef enum logic [1:0] {
      CAP_IDLE,
      CAP_RUN,
      CAP_DONE
   } cap_state_e;

   // clip a 17 bit intermediate back into the comp_t range
   function automatic comp_t sat_comp(input logic signed [16:0] x);
      if (x > 17'sd32767) return 16'sh7fff;
      if (x < -17'sd32768) return 16'sh8000;
      return x[15:0];
   endfunction

endpackage
